//--- sim.f
+incdir+logic
logic/sparse_pkg.sv
logic/match_if.sv
logic/prefix_sum.sv
logic/match_pri_enc.sv
logic/subchunk_base_regs.sv
logic/data_addr_cal.sv
logic/sparse_fetch_top.sv
verif/sparse_fetch_tb.sv

//--- Makefile
# Verilator flow for the sparse fetch front end
# override any variable on the command line, e.g. make sim TOP=sparse_fetch_tb

VERILATOR ?= verilator
TOP       ?= sparse_fetch_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# exit status of the binary is the pass or fail result
sim: $(BIN)
	./$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/sparse_fetch_tb.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

module sparse_fetch_tb
	import sparse_pkg::*;
();

	//////////////////////////////////////////////////
	// run limit
	//////////////////////////////////////////////////

	// 55 windows in all
	// each costs at most a drive cycle plus WIN_SIZE matches and a start
	localparam int MAX_WINDOWS = 80;
	localparam int WIN_CYCLES  = `WIN_SIZE + 4;
	localparam int CYCLE_LIMIT = MAX_WINDOWS * WIN_CYCLES + 400;

	logic        clk_i;
	logic        rst_i;
	logic        sub_chunk_start_i;
	fil_idx_t    fil_idx_i;
	logic        map_valid_i;
	win_map_t    ifm_map_i;
	win_map_t    fil_map_i;
	logic        cfg_we_i;
	fil_idx_t    cfg_idx_i;
	chunk_addr_t cfg_base_i;
	logic        busy_o;
	logic        rd_dat_valid_o;
	chunk_addr_t rd_dat_addr_o;
	logic        win_end_o;

	// reference running base and table copy
	chunk_addr_t model_base;
	chunk_addr_t model_tab [`FIL_ROWS_MAX];

	logic [31:0] lfsr_q;
	int          cycle_cnt = 0;

	sparse_fetch_top sparse_fetch_top_inst (
		 .clk_i             (clk_i)
		,.rst_i             (rst_i)
		,.sub_chunk_start_i (sub_chunk_start_i)
		,.fil_idx_i         (fil_idx_i)
		,.map_valid_i       (map_valid_i)
		,.ifm_map_i         (ifm_map_i)
		,.fil_map_i         (fil_map_i)
		,.cfg_we_i          (cfg_we_i)
		,.cfg_idx_i         (cfg_idx_i)
		,.cfg_base_i        (cfg_base_i)
		,.busy_o            (busy_o)
		,.rd_dat_valid_o    (rd_dat_valid_o)
		,.rd_dat_addr_o     (rd_dat_addr_o)
		,.win_end_o         (win_end_o)
	);

	// 20 ns period
	initial begin
		clk_i = 1'b0;
		forever #10 clk_i = ~clk_i;
	end

	// watchdog
	always @(posedge clk_i) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
			abort_run("stopping at first mismatch");
		end
	endtask

	// taps 32,22,2,1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one step per bit taken
	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
	endtask

	// input nonzeros below a position
	function automatic int ones_below(input win_map_t m, input int pos);
		int n;
		n = 0;
		for (int i = 0; i < pos; i++) begin
			if (m[i]) begin
				n++;
			end
		end
		return n;
	endfunction

	//////////////////////////////////////////////////
	// drivers
	//////////////////////////////////////////////////

	task automatic write_table(input fil_idx_t idx, input chunk_addr_t base);
		@(posedge clk_i);
		cfg_we_i   <= 1'b1;
		cfg_idx_i  <= idx;
		cfg_base_i <= base;
		@(posedge clk_i);
		cfg_we_i <= 1'b0;
		model_tab[idx] = base;
	endtask

	task automatic start_subchunk(input fil_idx_t idx);
		@(posedge clk_i);
		sub_chunk_start_i <= 1'b1;
		fil_idx_i         <= idx;
		@(posedge clk_i);
		sub_chunk_start_i <= 1'b0;
		model_base = model_tab[idx];
	endtask

	// walk matches until win_end and check count, order and addresses
	task automatic collect_window(input win_map_t ifm, input win_map_t fil);
		int          exp_pos [$];
		int          n_got;
		int          waited;
		logic        done;
		chunk_addr_t exp_addr;
		for (int i = 0; i < `WIN_SIZE; i++) begin
			if (ifm[i] && fil[i]) begin
				exp_pos.push_back(i);
			end
		end
		n_got  = 0;
		waited = 0;
		done   = 1'b0;
		while (!done) begin
			@(negedge clk_i);
			waited++;
			if (waited > `WIN_SIZE + 1) begin
				abort_run("window never ended with win_end_o");
			end
			check_val("busy_o", 32'(busy_o), 32'd1);
			if (rd_dat_valid_o) begin
				if (n_got >= exp_pos.size()) begin
					abort_run($sformatf("got more matches than the %0d expected",
						exp_pos.size()));
				end
				// matched bits are input nonzeros so address order follows position order
				exp_addr = model_base + chunk_addr_t'(ones_below(ifm, exp_pos[n_got]));
				check_val("rd_dat_addr_o", 32'(rd_dat_addr_o), 32'(exp_addr));
				n_got++;
			end else if (n_got < exp_pos.size()) begin
				abort_run($sformatf("match %0d of %0d missing", n_got + 1, exp_pos.size()));
			end
			check_val("win_end_o", 32'(win_end_o), 32'(n_got == exp_pos.size()));
			done = win_end_o;
		end
		// base steps past the whole window
		model_base = model_base + chunk_addr_t'(ones_below(ifm, `WIN_SIZE));
	endtask

	// map_valid_i sampled once and matches follow from the next cycle
	task automatic run_window(input win_map_t ifm, input win_map_t fil);
		@(posedge clk_i);
		map_valid_i <= 1'b1;
		ifm_map_i   <= ifm;
		fil_map_i   <= fil;
		// nothing in flight while the window is offered
		@(negedge clk_i);
		check_val("busy_o", 32'(busy_o), 32'd0);
		check_val("rd_dat_valid_o", 32'(rd_dat_valid_o), 32'd0);
		check_val("win_end_o", 32'(win_end_o), 32'd0);
		@(posedge clk_i);
		map_valid_i <= 1'b0;
		collect_window(ifm, fil);
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////

	task automatic test_reset_state();
		@(negedge clk_i);
		check_val("busy_o", 32'(busy_o), 32'd0);
		check_val("rd_dat_valid_o", 32'(rd_dat_valid_o), 32'd0);
		check_val("win_end_o", 32'(win_end_o), 32'd0);
		// base comes out of reset at 0
		run_window(16'h0ff0, 16'h3cf0);
		// every stride entry
		for (int i = 0; i < `FIL_ROWS_MAX; i++) begin
			start_subchunk(fil_idx_t'(i));
			run_window(16'hb5a3, 16'h0ff0);
		end
	endtask

	task automatic test_single_window();
		start_subchunk(fil_idx_t'(0));
		run_window(16'hf3c9, 16'hbe57);
	endtask

	task automatic test_back_to_back();
		run_window(16'h1234, 16'hffff);
		run_window(16'hffff, 16'h8001);
		run_window(16'h0f0f, 16'h3c3c);
		run_window(16'h8000, 16'h8000);
	endtask

	// no overlap yet the base still advances by 8
	task automatic test_empty_window();
		run_window(16'h00ff, 16'hff00);
		run_window(16'h0101, 16'h0101);
	endtask

	task automatic test_table_write();
		write_table(fil_idx_t'(1), 11'h2a5);
		start_subchunk(fil_idx_t'(1));
		run_window(16'h5555, 16'h7777);
		// addresses roll over 2047 near the top
		write_table(fil_idx_t'(2), 11'h7fa);
		start_subchunk(fil_idx_t'(2));
		run_window(16'hffff, 16'h8421);
		run_window(16'hc003, 16'hffff);
	endtask

	task automatic test_random_windows();
		logic [31:0] r;
		win_map_t    ifm;
		win_map_t    fil;
		for (int n = 0; n < 40; n++) begin
			take_bits(1, r);
			if (r[0] || n == 0) begin
				take_bits(2, r);
				start_subchunk(fil_idx_t'(r[1:0]));
			end
			take_bits(16, r);
			ifm = r[15:0];
			take_bits(16, r);
			fil = r[15:0];
			run_window(ifm, fil);
		end
	endtask

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		rst_i             = 1'b1;
		sub_chunk_start_i = 1'b0;
		fil_idx_i         = '0;
		map_valid_i       = 1'b0;
		ifm_map_i         = '0;
		fil_map_i         = '0;
		cfg_we_i          = 1'b0;
		cfg_idx_i         = '0;
		cfg_base_i        = '0;
		lfsr_q            = 32'h6ba9;
		model_base        = '0;
		for (int i = 0; i < `FIL_ROWS_MAX; i++) begin
			model_tab[i] = chunk_addr_t'(i * `SUBCHUNK_STRIDE);
		end
		repeat (2) @(posedge clk_i);
		rst_i <= 1'b0;
		test_reset_state();
		test_single_window();
		test_back_to_back();
		test_empty_window();
		test_table_write();
		test_random_windows();
		$display("Done: no errors");
		$finish;
	end

endmodule

//--- logic/sparse_fetch_top.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

// sparse operand fetch front end
// encoder -> address calculator, base table on the side
module sparse_fetch_top
	import sparse_pkg::*;
(
	 input  logic        clk_i
	,input  logic        rst_i

	// sub-chunk and window
	,input  logic        sub_chunk_start_i
	,input  fil_idx_t    fil_idx_i
	,input  logic        map_valid_i
	,input  win_map_t    ifm_map_i
	,input  win_map_t    fil_map_i

	// base table writes
	,input  logic        cfg_we_i
	,input  fil_idx_t    cfg_idx_i
	,input  chunk_addr_t cfg_base_i

	// status and read address
	,output logic        busy_o
	,output logic        rd_dat_valid_o
	,output chunk_addr_t rd_dat_addr_o
	,output logic        win_end_o
);

	// table entry for the filter row being started
	chunk_addr_t next_base_w;

	// match stream between encoder and address path
	match_if mi ();

	//////////////////////////////////////////////////
	// blocks
	//////////////////////////////////////////////////

	match_pri_enc u_match_pri_enc (
		 .clk_i       (clk_i)
		,.rst_i       (rst_i)
		,.map_valid_i (map_valid_i)
		,.ifm_map_i   (ifm_map_i)
		,.fil_map_i   (fil_map_i)
		,.busy_o      (busy_o)
		,.mi          (mi.enc)
	);

	subchunk_base_regs u_subchunk_base_regs (
		 .clk_i      (clk_i)
		,.rst_i      (rst_i)
		,.cfg_we_i   (cfg_we_i)
		,.cfg_idx_i  (cfg_idx_i)
		,.cfg_base_i (cfg_base_i)
		,.rd_idx_i   (fil_idx_i)
		,.base_o     (next_base_w)
	);

	data_addr_cal u_data_addr_cal (
		 .clk_i             (clk_i)
		,.rst_i             (rst_i)
		,.sub_chunk_start_i (sub_chunk_start_i)
		,.next_base_i       (next_base_w)
		,.mi                (mi.cal)
		,.rd_dat_valid_o    (rd_dat_valid_o)
		,.rd_dat_addr_o     (rd_dat_addr_o)
		,.win_end_o         (win_end_o)
	);

endmodule

//--- logic/data_addr_cal.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

// compressed buffer read address
// address = running base + input nonzeros below the match
module data_addr_cal
	import sparse_pkg::*;
(
	 input  logic        clk_i
	,input  logic        rst_i
	,input  logic        sub_chunk_start_i
	,input  chunk_addr_t next_base_i
	,match_if.cal        mi
	,output logic        rd_dat_valid_o
	,output chunk_addr_t rd_dat_addr_o
	,output logic        win_end_o
);

	// prefix counts of the registered input map
	win_cnt_t pfx_cnt_w [`WIN_SIZE+1];

	// first buffer word of the current window
	chunk_addr_t base_q;

	// offset of this match inside the window's packed data
	chunk_addr_t offs_w;

	// window's total input nonzeros
	chunk_addr_t win_pop_w;

	//////////////////////////////////////////////////
	// prefix count
	//////////////////////////////////////////////////

	prefix_sum u_prefix_sum (
		 .map_i (mi.ifm_map)
		,.cnt_o (pfx_cnt_w)
	);

	assign offs_w    = chunk_addr_t'(pfx_cnt_w[mi.match_pos]);
	assign win_pop_w = chunk_addr_t'(pfx_cnt_w[`WIN_SIZE]);

	//////////////////////////////////////////////////
	// running base
	//////////////////////////////////////////////////

	// start of sub-chunk reloads from the table
	// otherwise step past the window just consumed
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			base_q <= '0;
		end else if (sub_chunk_start_i) begin
			base_q <= next_base_i;
		end else if (mi.win_end) begin
			// wraps mod 2^11
			base_q <= base_q + win_pop_w;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	// same cycle as the registered match
	assign rd_dat_addr_o  = base_q + offs_w;
	assign rd_dat_valid_o = mi.match_valid;
	assign win_end_o      = mi.win_end;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a reload mid-window would lose the base step
	a_start_in_window: assert property (@(posedge clk_i) disable iff (rst_i)
		sub_chunk_start_i |-> !(mi.win_end || mi.match_valid));

endmodule

//--- logic/subchunk_base_regs.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

// table of sub-chunk starting bases, one per filter row
module subchunk_base_regs
	import sparse_pkg::*;
(
	 input  logic        clk_i
	,input  logic        rst_i
	,input  logic        cfg_we_i
	,input  fil_idx_t    cfg_idx_i
	,input  chunk_addr_t cfg_base_i
	,input  fil_idx_t    rd_idx_i
	,output chunk_addr_t base_o
);

	// base of each filter row inside the compressed buffer
	chunk_addr_t base_q [`FIL_ROWS_MAX];

	//////////////////////////////////////////////////
	// write port
	//////////////////////////////////////////////////

	// reset lays rows out at an even stride
	// software may move them afterwards
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			for (int i = 0; i < `FIL_ROWS_MAX; i++) begin
				base_q[i] <= chunk_addr_t'(i * `SUBCHUNK_STRIDE);
			end
		end else if (cfg_we_i) begin
			// one entry per strobe, seen next cycle
			base_q[cfg_idx_i] <= cfg_base_i;
		end
	end

	//////////////////////////////////////////////////
	// read port
	//////////////////////////////////////////////////

	// plain mux, no read latency
	// same-cycle write shows up on the following cycle
	assign base_o = base_q[rd_idx_i];

endmodule

//--- logic/match_pri_enc.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

// matched-position scanner
// latches a window's maps, then walks the AND mask lowest bit first
module match_pri_enc
	import sparse_pkg::*;
(
	 input  logic     clk_i
	,input  logic     rst_i
	,input  logic     map_valid_i
	,input  win_map_t ifm_map_i
	,input  win_map_t fil_map_i
	,output logic     busy_o
	,match_if.enc     mi
);

	scan_state_e state_q;

	// input map kept for the address prefix count
	win_map_t ifm_map_q;

	// matched positions not yet emitted
	win_map_t pend_q;

	// lowest pending bit, and the mask with it removed
	win_pos_t low_pos_w;
	win_map_t pend_rest_w;

	// scan flags for this cycle
	logic run_w;
	logic hit_w;
	logic last_w;

	//////////////////////////////////////////////////
	// priority pick
	//////////////////////////////////////////////////

	// scan from the top so the lowest set bit wins
	always_comb begin
		low_pos_w = '0;
		for (int i = `WIN_SIZE - 1; i >= 0; i--) begin
			if (pend_q[i]) begin
				low_pos_w = win_pos_t'(i);
			end
		end
	end

	// x & (x-1) clears the lowest set bit
	assign pend_rest_w = pend_q & (pend_q - win_map_t'(1));

	assign run_w  = (state_q == SCAN_RUN);
	assign hit_w  = run_w && (|pend_q);
	// empty mask also ends the window, without a match
	assign last_w = run_w && !(|pend_rest_w);

	//////////////////////////////////////////////////
	// scan FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= SCAN_IDLE;
			pend_q  <= '0;
		end else if (map_valid_i) begin
			// new window, only legal while idle or right at win_end
			state_q <= SCAN_RUN;
			pend_q  <= ifm_map_i & fil_map_i;
		end else if (run_w) begin
			pend_q <= pend_rest_w;
			if (last_w) begin
				state_q <= SCAN_IDLE;
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk_i) begin
		if (map_valid_i) begin
			ifm_map_q <= ifm_map_i;
		end
	end

	//////////////////////////////////////////////////
	// outputs
	//////////////////////////////////////////////////

	assign mi.match_valid = hit_w;
	assign mi.match_pos   = low_pos_w;
	assign mi.win_end     = last_w;
	assign mi.ifm_map     = ifm_map_q;

	// high from first match cycle through win_end
	assign busy_o = run_w;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// upstream must wait for busy to drop
	a_map_while_busy: assert property (@(posedge clk_i) disable iff (rst_i)
		map_valid_i |-> !busy_o);

	// a match needs an accepted window or an unfinished scan just before it
	a_match_from_idle: assert property (@(posedge clk_i) disable iff (rst_i)
		mi.match_valid |-> $past(map_valid_i || (busy_o && !mi.win_end)));

endmodule

//--- logic/prefix_sum.sv
`timescale 1ns/1ps
`include "sparse_config.svh"

// exclusive prefix count of a sparsity map
// cnt_o[k] = number of set bits in map_i[k-1:0]
// cnt_o[WIN_SIZE] = total popcount
module prefix_sum
	import sparse_pkg::*;
(
	 input  win_map_t map_i
	,output win_cnt_t cnt_o [`WIN_SIZE+1]
);

	// running count at each tap of the chain
	win_cnt_t chain_w [`WIN_SIZE+1];

	//////////////////////////////////////////////////
	// adder chain
	//////////////////////////////////////////////////

	// nothing lies below position 0
	assign chain_w[0] = '0;

	// one small adder per element
	// plain chain, left for synthesis to retime or rebalance
	genvar k;
	generate
		for (k = 0; k < `WIN_SIZE; k++) begin : g_chain
			assign chain_w[k+1] = chain_w[k] + win_cnt_t'(map_i[k]);
		end
	endgenerate

	// tap out every stage, last one is the popcount
	genvar j;
	generate
		for (j = 0; j <= `WIN_SIZE; j++) begin : g_out
			assign cnt_o[j] = chain_w[j];
		end
	endgenerate

endmodule

//--- logic/match_if.sv
`timescale 1ns/1ps

// one match per cycle from encoder to address calculator
interface match_if
	import sparse_pkg::*;
();

	// high for one cycle per matched position
	logic match_valid;

	// matched position, lowest first
	win_pos_t match_pos;

	// with the last match, or alone for an empty window
	logic win_end;

	// registered input map, stable for the whole window
	win_map_t ifm_map;

	//////////////////////////////////////////////////
	// modports
	//////////////////////////////////////////////////

	// encoder side drives everything
	modport enc (output match_valid, output match_pos, output win_end, output ifm_map);

	// address side only listens
	modport cal (input match_valid, input match_pos, input win_end, input ifm_map);

endinterface

//--- logic/sparse_pkg.sv
`include "sparse_config.svh"

package sparse_pkg;

	//////////////////////////////////////////////////
	// derived widths
	//////////////////////////////////////////////////

	// bits to name one position inside a window
	localparam int WIN_POS_W = $clog2(`WIN_SIZE);

	// one extra bit so the address can hold CHUNK_SIZE itself
	localparam int CHUNK_ADDR_W = $clog2(`CHUNK_SIZE) + 1;

	// bits to select one table entry
	localparam int FIL_IDX_W = $clog2(`FIL_ROWS_MAX);

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	// encoder scan state
	typedef enum logic {
		SCAN_IDLE = 1'b0,
		SCAN_RUN  = 1'b1
	} scan_state_e;

	// one bit per window element, set where nonzero
	typedef logic [`WIN_SIZE-1:0] win_map_t;

	// position in the window
	typedef logic [WIN_POS_W-1:0] win_pos_t;

	// count 0 .. WIN_SIZE, one bit wider than a position
	typedef logic [WIN_POS_W:0] win_cnt_t;

	// compressed buffer read address, wraps mod 2^11
	typedef logic [CHUNK_ADDR_W-1:0] chunk_addr_t;

	// base table index, one per filter row
	typedef logic [FIL_IDX_W-1:0] fil_idx_t;

endpackage

//--- logic/sparse_config.svh
`ifndef SPARSE_CONFIG_SVH
`define SPARSE_CONFIG_SVH

//////////////////////////////////////////////////
// window geometry
//////////////////////////////////////////////////

// elements per window, also bits per sparsity map
`define WIN_SIZE 16

//////////////////////////////////////////////////
// compressed buffer
//////////////////////////////////////////////////

// buffer depth in words
// address carries one extra bit so it can count up to the depth itself
`define CHUNK_SIZE 1024

//////////////////////////////////////////////////
// sub-chunk base table
//////////////////////////////////////////////////

// one entry per filter row
`define FIL_ROWS_MAX 4

// spacing of entries after reset
`define SUBCHUNK_STRIDE 128

`endif
